/* Makefile */
# Verilator build and run of the execution slice testbench

VERILATOR ?= verilator
TOP       ?= ooo_exec_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

# pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/ooo_exec_chk.sv */
////////////////////
// concurrent checks on dispatch, issue and cdb of the slice
// bound into ooo_exec_top by the testbench
////////////////////

`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_exec_chk import ooo_pkg::*; (
    input logic      clock,
    input logic      reset,
    input logic      squash,
    input dispatch_s dispatch,
    input logic      issue_take,
    input logic      full,
    input cdb_s      cdb
);

    int fail_count = 0;

    // entry count, up on accepted dispatch, down on issue
    int occupancy;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(dispatch.valid && !full) - int'(issue_take);
        end
    end

    ////////////////////
    // cdb
    ////////////////////
    cdb_one_cycle: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |=> !cdb.valid)
        else begin
            fail_count++;
            $error("cdb valid held for two cycles");
        end

    cdb_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
        cdb.valid |-> cdb.tag != `ZERO_TAG)
        else begin
            fail_count++;
            $error("cdb carried the zero tag");
        end

    ////////////////////
    // dispatch and reset
    ////////////////////
    // a dispatch taken while full would push the count past depth
    full_honest: assert property (@(posedge clock) disable iff (reset)
        (occupancy <= `RS_DEPTH) && (full == (occupancy == `RS_DEPTH)))
        else begin
            fail_count++;
            $error("full does not match station occupancy");
        end

    quiet_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> !full && !cdb.valid)
        else begin
            fail_count++;
            $error("full or cdb valid high right after reset");
        end

    // two clean cycles after squash
    squash_first: assert property (@(posedge clock) disable iff (reset)
        squash |=> !cdb.valid)
        else begin
            fail_count++;
            $error("cdb valid in the first cycle after squash");
        end

    squash_second: assert property (@(posedge clock) disable iff (reset)
        $past(squash) |=> !cdb.valid)
        else begin
            fail_count++;
            $error("cdb valid in the second cycle after squash");
        end

endmodule

/* bench/ooo_exec_tb.sv */
////////////////////
// testbench for the execution slice
// drives dispatch and ext_cdb and checks each cdb result against a tag table
////////////////////

`timescale 1ns/1ps
`include "ooo_params.svh"

module ooo_exec_tb import ooo_pkg::*;;

    localparam int NTAGS      = 1 << `TAG_W;
    localparam int WAIT_LIMIT = 60;

    typedef logic [2*`DATA_W-1:0] wide_t;

    logic      clock;
    logic      reset;
    logic      squash;
    dispatch_s dispatch;
    cdb_s      ext_cdb;
    logic      full;
    cdb_s      cdb;

    // expected result per tag and what the cdb delivered
    data_t exp_val  [NTAGS];
    logic  expected [NTAGS];
    int    seen_cnt [NTAGS];
    data_t seen_val [NTAGS];
    tag_t  cdb_order [$];
    logic  saw_full;

    logic [31:0] rng;
    string       cur_test;
    int          errors;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;

    ooo_exec_top dut_i (
        .clock    (clock),
        .reset    (reset),
        .squash   (squash),
        .dispatch (dispatch),
        .ext_cdb  (ext_cdb),
        .full     (full),
        .cdb      (cdb)
    );

    bind ooo_exec_top ooo_exec_chk chk_i (
        .clock      (clock),
        .reset      (reset),
        .squash     (squash),
        .dispatch   (dispatch),
        .issue_take (issue_take),
        .full       (full),
        .cdb        (cdb)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    ////////////////////
    // helpers
    ////////////////////
    // xorshift32 step
    function automatic data_t rand_word();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return data_t'(rng);
    endfunction

    // reference ALU with the product taken at full width then cut
    function automatic data_t model_alu(alu_op_e op, data_t a, data_t b);
        wide_t prod;
        prod = wide_t'(a) * wide_t'(b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            default: return prod[`DATA_W-1:0];
        endcase
    endfunction

    function automatic operand_s ready_opnd(data_t v);
        operand_s o;
        o.tag   = `ZERO_TAG;
        o.value = v;
        o.ready = 1'b1;
        return o;
    endfunction

    // value is junk until the producer broadcasts
    function automatic operand_s wait_opnd(tag_t t);
        operand_s o;
        o.tag   = t;
        o.value = data_t'(32'hdead_beef);
        o.ready = 1'b0;
        return o;
    endfunction

    function automatic int total_errors();
        return errors + dut_i.chk_i.fail_count;
    endfunction

    function automatic logic all_seen();
        for (int t = 0; t < NTAGS; t++) begin
            if (expected[t] && seen_cnt[t] == 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // one cycle with outputs looked at mid-cycle
    task automatic tick();
        @(negedge clock);
        if (cdb.valid) begin
            seen_cnt[cdb.tag] = seen_cnt[cdb.tag] + 1;
            seen_val[cdb.tag] = cdb.value;
            cdb_order.push_back(cdb.tag);
        end
        if (full) begin
            saw_full = 1'b1;
        end
    endtask

    task automatic start_test(string name);
        cur_test        = name;
        errors_at_start = total_errors();
        saw_full        = 1'b0;
        cdb_order.delete();
        for (int t = 0; t < NTAGS; t++) begin
            expected[t] = 1'b0;
            seen_cnt[t] = 0;
        end
    endtask

    task automatic expect_result(tag_t t, data_t v);
        exp_val[t]  = v;
        expected[t] = 1'b1;
    endtask

    // held and retried while full
    task automatic send(alu_op_e op, tag_t dest, operand_s s1, operand_s s2);
        int n;
        dispatch.valid = 1'b1;
        dispatch.op    = op;
        dispatch.dest  = dest;
        dispatch.src1  = s1;
        dispatch.src2  = s2;
        n = 0;
        while (full && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (full) begin
            $display("test %s: dispatch of tag %0d never accepted, station stayed full",
                     cur_test, dest);
            errors++;
        end
        tick();
        dispatch.valid = 1'b0;
    endtask

    task automatic pulse_ext(tag_t t, data_t v);
        ext_cdb.valid = 1'b1;
        ext_cdb.tag   = t;
        ext_cdb.value = v;
        tick();
        ext_cdb.valid = 1'b0;
    endtask

    task automatic wait_results(int limit);
        int n;
        n = 0;
        while (!all_seen() && n < limit) begin
            tick();
            n++;
        end
        for (int t = 0; t < NTAGS; t++) begin
            if (expected[t] && seen_cnt[t] == 0) begin
                $display("test %s: result for tag %0d missing after %0d cycles",
                         cur_test, t, limit);
                errors++;
            end
        end
        // settle so a late duplicate lands here
        repeat (4) tick();
        for (int t = 0; t < NTAGS; t++) begin
            if (expected[t] && seen_cnt[t] != 0) begin
                assert (seen_cnt[t] == 1) else begin
                    $display("test %s: tag %0d broadcast %0d times", cur_test, t, seen_cnt[t]);
                    errors++;
                end
                assert (seen_val[t] == exp_val[t]) else begin
                    $display("[ERROR] %0t ns: tag %0d expected %h got %h",
                             $time, t, exp_val[t], seen_val[t]);
                    errors++;
                end
            end else if (!expected[t]) begin
                assert (seen_cnt[t] == 0) else begin
                    $display("test %s: unexpected result for tag %0d", cur_test, t);
                    errors++;
                end
            end
        end
    endtask

    task automatic finish_test();
        if (total_errors() == errors_at_start) begin
            tests_passed++;
            $display("test %s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: fail", cur_test);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////
    initial begin
        alu_op_e op;
        data_t   a;
        data_t   b;
        data_t   v;
        rng          = 32'd16;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        saw_full     = 1'b0;
        reset        = 1'b1;
        squash       = 1'b0;
        dispatch     = '0;
        ext_cdb      = '0;
        repeat (4) tick();
        reset = 1'b0;

        // every opcode with ready operands
        start_test("independent");
        for (int i = 0; i <= int'(OP_MUL); i++) begin
            op = alu_op_e'(i);
            a  = rand_word();
            b  = rand_word();
            expect_result(tag_t'(i + 1), model_alu(op, a, b));
            send(op, tag_t'(i + 1), ready_opnd(a), ready_opnd(b));
        end
        wait_results(WAIT_LIMIT);
        finish_test();

        // consumer wakes on the multiply broadcast
        start_test("cdb dependence");
        a = rand_word();
        b = rand_word();
        v = rand_word();
        expect_result(tag_t'(1), model_alu(OP_MUL, a, b));
        send(OP_MUL, tag_t'(1), ready_opnd(a), ready_opnd(b));
        expect_result(tag_t'(2), model_alu(OP_SUB, exp_val[1], v));
        send(OP_SUB, tag_t'(2), wait_opnd(tag_t'(1)), ready_opnd(v));
        wait_results(WAIT_LIMIT);
        finish_test();

        // tag 9 only ever shows up on ext_cdb
        start_test("external wakeup");
        a = rand_word();
        v = rand_word();
        expect_result(tag_t'(3), model_alu(OP_XOR, v, a));
        send(OP_XOR, tag_t'(3), wait_opnd(tag_t'(9)), ready_opnd(a));
        repeat (12) tick();
        assert (seen_cnt[3] == 0) else begin
            $display("test %s: tag 3 completed before its external operand arrived", cur_test);
            errors++;
        end
        pulse_ext(tag_t'(9), v);
        wait_results(WAIT_LIMIT);
        finish_test();

        // long multiply blocks the unit while the station fills and the last op is held
        start_test("back-pressure");
        for (int i = 0; i < `RS_DEPTH + 2; i++) begin
            op = (i == 0) ? OP_MUL : alu_op_e'(i % 6);
            a  = rand_word();
            b  = rand_word();
            expect_result(tag_t'(i + 1), model_alu(op, a, b));
            send(op, tag_t'(i + 1), ready_opnd(a), ready_opnd(b));
        end
        assert (saw_full) else begin
            $display("test %s: full never rose with the station loaded", cur_test);
            errors++;
        end
        wait_results(WAIT_LIMIT);
        finish_test();

        // tags 1, 2, 3 and 5 stay unexpected so any broadcast of them is flagged
        start_test("squash");
        send(OP_MUL, tag_t'(1), ready_opnd(rand_word()), ready_opnd(rand_word()));
        send(OP_ADD, tag_t'(2), ready_opnd(rand_word()), ready_opnd(rand_word()));
        send(OP_OR, tag_t'(3), wait_opnd(tag_t'(12)), ready_opnd(rand_word()));
        // multiply issued one edge after its dispatch
        // first squash lands on its last execution cycle
        repeat (`MUL_LATENCY - 2) tick();
        squash = 1'b1;
        tick();
        squash = 1'b0;
        repeat (2) tick();
        // second squash lands on the broadcast cycle of a new multiply
        send(OP_MUL, tag_t'(5), ready_opnd(rand_word()), ready_opnd(rand_word()));
        repeat (`MUL_LATENCY + 1) tick();
        squash = 1'b1;
        tick();
        squash = 1'b0;
        repeat (2 * `MUL_LATENCY + 4) tick();
        a = rand_word();
        b = rand_word();
        expect_result(tag_t'(4), model_alu(OP_AND, a, b));
        send(OP_AND, tag_t'(4), ready_opnd(a), ready_opnd(b));
        wait_results(WAIT_LIMIT);
        finish_test();

        // one ext broadcast readies every entry at once
        // entry i holds tag i + 1
        start_test("fairness");
        v = rand_word();
        for (int i = 0; i < `RS_DEPTH; i++) begin
            op = (i == 0) ? OP_MUL : alu_op_e'(rand_word() % 7);
            b  = rand_word();
            expect_result(tag_t'(i + 1), model_alu(op, v, b));
            send(op, tag_t'(i + 1), wait_opnd(tag_t'(10)), ready_opnd(b));
        end
        pulse_ext(tag_t'(10), v);
        wait_results(`RS_DEPTH * (`MUL_LATENCY + 1) + 8);
        // pointer sits one past slot 0 after the last AND so slot 0 is served last
        for (int i = 0; i < cdb_order.size(); i++) begin
            assert (cdb_order[i] == tag_t'((i + 1) % `RS_DEPTH + 1)) else begin
                $display("[ERROR] %0t ns: result %0d came from tag %0d, expected tag %0d",
                         $time, i, cdb_order[i], (i + 1) % `RS_DEPTH + 1);
                errors++;
            end
        end
        finish_test();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* design/exec_alu.sv */
////////////////////
// operand latch and arithmetic of the integer unit
// result goes onto the cdb register for one cycle on bcast
////////////////////

`timescale 1ns/1ps

module exec_alu import ooo_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  logic   squash,
    input  logic   issue_take,
    input  issue_s issue_word,
    input  logic   bcast,
    output cdb_s   cdb
);

    // operation in execution
    issue_s op_r;
    data_t  result;

    always_ff @(posedge clock) begin
        if (issue_take) begin
            op_r <= issue_word;
        end
    end

    ////////////////////
    // arithmetic
    ////////////////////
    always_comb begin
        case (op_r.op)
            OP_ADD:  result = op_r.src1 + op_r.src2;
            OP_SUB:  result = op_r.src1 - op_r.src2;
            OP_AND:  result = op_r.src1 & op_r.src2;
            OP_OR:   result = op_r.src1 | op_r.src2;
            OP_XOR:  result = op_r.src1 ^ op_r.src2;
            // shift amount from low five bits
            OP_SLL:  result = op_r.src1 << op_r.src2[4:0];
            // low half of the product
            OP_MUL:  result = op_r.src1 * op_r.src2;
            default: result = '0;
        endcase
    end

    ////////////////////
    // cdb register
    ////////////////////
    // valid lasts one cycle, squash kills a pending write
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= bcast;
            if (bcast) begin
                cdb.tag   <= op_r.dest;
                cdb.value <= result;
            end
        end
    end

endmodule

/* design/fu_control.sv */
////////////////////
// control FSM of the integer unit
// idle takes a pick, exec waits on the timer, bcast fires the cdb write
////////////////////

`timescale 1ns/1ps
`include "ooo_params.svh"

module fu_control import ooo_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    squash,
    input  logic    pick_valid,
    input  alu_op_e issue_op,
    input  logic    expired,
    output logic    issue_take,
    output logic    load,
    output cnt_t    load_value,
    output logic    bcast
);

    fu_state_e state;
    fu_state_e state_next;

    ////////////////////
    // outputs
    ////////////////////
    // one op at a time, only idle accepts
    assign issue_take = (state == FU_IDLE) && pick_valid;
    assign load       = issue_take;
    // multiply runs the long count, all else one cycle
    assign load_value = (issue_op == OP_MUL) ? cnt_t'(`MUL_LATENCY) : cnt_t'(1);
    assign bcast      = (state == FU_BCAST);

    ////////////////////
    // next state
    ////////////////////
    always_comb begin
        state_next = state;
        case (state)
            FU_IDLE: begin
                if (pick_valid) begin
                    state_next = FU_EXEC;
                end
            end
            FU_EXEC: begin
                // last execution cycle
                if (expired) begin
                    state_next = FU_BCAST;
                end
            end
            FU_BCAST: begin
                state_next = FU_IDLE;
            end
            default: begin
                state_next = FU_IDLE;
            end
        endcase
    end

    // squash drops whatever is in flight
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            state <= FU_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* design/issue_select.sv */
////////////////////
// round-robin pick of one ready station entry
// pointer moves one past the granted slot when the unit takes it
////////////////////

`timescale 1ns/1ps
`include "ooo_params.svh"

module issue_select import ooo_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       squash,
    input  slot_mask_t ready_mask,
    input  logic       issue_take,
    output logic       pick_valid,
    output slot_t      pick_slot
);

    // first slot to look at
    slot_t ptr;

    // search from ptr upward with wrap
    // downward loop keeps the nearest hit
    always_comb begin
        int idx;
        pick_valid = 1'b0;
        pick_slot  = '0;
        for (int k = `RS_DEPTH - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % `RS_DEPTH;
            if (ready_mask[idx]) begin
                pick_valid = 1'b1;
                pick_slot  = slot_t'(idx);
            end
        end
    end

    // advance past the grant so nothing starves
    always_ff @(posedge clock) begin
        if (reset || squash) begin
            ptr <= '0;
        end else if (issue_take) begin
            if (int'(pick_slot) == `RS_DEPTH - 1) begin
                ptr <= '0;
            end else begin
                ptr <= pick_slot + slot_t'(1);
            end
        end
    end

endmodule

/* design/latency_timer.sv */
////////////////////
// execution cycle counter for the integer unit
// load starts it, expired flags the last cycle
////////////////////

`timescale 1ns/1ps

module latency_timer import ooo_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic squash,
    input  logic load,
    input  cnt_t load_value,
    output logic expired
);

    // zero means idle
    cnt_t count;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (count != '0) begin
            count <= count - cnt_t'(1);
        end
    end

    // high while the count sits at one
    assign expired = (count == cnt_t'(1));

endmodule

/* design/ooo_exec_top.sv */
////////////////////
// top of the slice, one station feeding one integer unit
// own cdb loops back into the station for wakeup
////////////////////

`timescale 1ns/1ps

module ooo_exec_top import ooo_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      squash,
    input  dispatch_s dispatch,
    input  cdb_s      ext_cdb,
    output logic      full,
    output cdb_s      cdb
);

    // station to selector
    slot_mask_t ready_mask;
    logic       pick_valid;
    slot_t      pick_slot;
    // station to unit
    issue_s     issue_word;
    logic       issue_take;
    // control to timer and alu
    logic       load;
    cnt_t       load_value;
    logic       expired;
    logic       bcast;

    rs_station rs_station_i (
        .clock      (clock),
        .reset      (reset),
        .squash     (squash),
        .dispatch   (dispatch),
        .cdb        (cdb),
        .ext_cdb    (ext_cdb),
        .issue_take (issue_take),
        .pick_slot  (pick_slot),
        .full       (full),
        .ready_mask (ready_mask),
        .issue_word (issue_word)
    );

    issue_select issue_select_i (
        .clock      (clock),
        .reset      (reset),
        .squash     (squash),
        .ready_mask (ready_mask),
        .issue_take (issue_take),
        .pick_valid (pick_valid),
        .pick_slot  (pick_slot)
    );

    // opcode of the picked entry picks the latency
    fu_control fu_control_i (
        .clock      (clock),
        .reset      (reset),
        .squash     (squash),
        .pick_valid (pick_valid),
        .issue_op   (issue_word.op),
        .expired    (expired),
        .issue_take (issue_take),
        .load       (load),
        .load_value (load_value),
        .bcast      (bcast)
    );

    latency_timer latency_timer_i (
        .clock      (clock),
        .reset      (reset),
        .squash     (squash),
        .load       (load),
        .load_value (load_value),
        .expired    (expired)
    );

    exec_alu exec_alu_i (
        .clock      (clock),
        .reset      (reset),
        .squash     (squash),
        .issue_take (issue_take),
        .issue_word (issue_word),
        .bcast      (bcast),
        .cdb        (cdb)
    );

endmodule

/* design/ooo_params.svh */
////////////////////
// sizing macros for the execution slice
// included by the package and by any module that needs the numbers
////////////////////

`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// station entries
`define RS_DEPTH 4

// producer tag and operand widths
`define TAG_W 4
`define DATA_W 32

// tag 0 means the operand has no producer
`define ZERO_TAG ({`TAG_W{1'b0}})

// multiply execution cycles, at least 2
`define MUL_LATENCY 4

`endif

/* design/ooo_pkg.sv */
////////////////////
// shared types for the reservation station slice
// modules pull these in with a wildcard import
////////////////////

`include "ooo_params.svh"

package ooo_pkg;

    ////////////////////
    // plain vectors
    ////////////////////
    typedef logic [`TAG_W-1:0]              tag_t;
    typedef logic [`DATA_W-1:0]             data_t;
    typedef logic [$clog2(`RS_DEPTH)-1:0]   slot_t;
    typedef logic [`RS_DEPTH-1:0]           slot_mask_t;
    // wide enough to hold MUL_LATENCY
    typedef logic [$clog2(`MUL_LATENCY+1)-1:0] cnt_t;

    ////////////////////
    // enums
    ////////////////////
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_MUL
    } alu_op_e;

    // unit control states
    typedef enum logic [1:0] {
        FU_IDLE,
        FU_EXEC,
        FU_BCAST
    } fu_state_e;

    ////////////////////
    // bundles
    ////////////////////
    // source operand, value valid only when ready
    typedef struct packed {
        tag_t  tag;
        data_t value;
        logic  ready;
    } operand_s;

    typedef struct packed {
        logic     valid;
        alu_op_e  op;
        tag_t     dest;
        operand_s src1;
        operand_s src2;
    } dispatch_s;

    // result bus word
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } cdb_s;

    // what the station hands to the unit
    typedef struct packed {
        alu_op_e op;
        tag_t    dest;
        data_t   src1;
        data_t   src2;
    } issue_s;

endpackage

/* design/rs_station.sv */
////////////////////
// reservation station entries with dispatch, wakeup and release
// dispatch is taken when valid and not full, the unit frees a slot on issue_take
////////////////////

`timescale 1ns/1ps
`include "ooo_params.svh"

module rs_station import ooo_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       squash,
    input  dispatch_s  dispatch,
    input  cdb_s       cdb,
    input  cdb_s       ext_cdb,
    input  logic       issue_take,
    input  slot_t      pick_slot,
    output logic       full,
    output slot_mask_t ready_mask,
    output issue_s     issue_word
);

    ////////////////////
    // storage
    ////////////////////
    slot_mask_t busy;
    slot_mask_t busy_next;
    alu_op_e    op_q   [`RS_DEPTH];
    tag_t       dest_q [`RS_DEPTH];
    operand_s   src1_q [`RS_DEPTH];
    operand_s   src2_q [`RS_DEPTH];

    // allocation
    slot_mask_t release_mask;
    slot_mask_t free_mask;
    slot_t      alloc_slot;
    logic       dispatch_take;

    // compare one operand against both result buses
    // own cdb first, the two never carry the same tag together
    function automatic operand_s snoop(operand_s opnd, cdb_s own, cdb_s ext);
        operand_s res;
        res = opnd;
        if (opnd.tag == `ZERO_TAG) begin
            // no producer, value already final
            res.ready = 1'b1;
        end else if (!opnd.ready) begin
            if (own.valid && own.tag == opnd.tag) begin
                res.value = own.value;
                res.ready = 1'b1;
            end else if (ext.valid && ext.tag == opnd.tag) begin
                res.value = ext.value;
                res.ready = 1'b1;
            end
        end
        return res;
    endfunction

    ////////////////////
    // dispatch side
    ////////////////////
    assign full          = &busy;
    assign dispatch_take = dispatch.valid && !full;

    // slot leaving this cycle counts as free
    assign release_mask = issue_take ? (slot_mask_t'(1) << pick_slot) : '0;
    assign free_mask    = ~busy | release_mask;

    // lowest free slot, scan downward so the smallest index wins
    always_comb begin
        alloc_slot = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (free_mask[i]) begin
                alloc_slot = slot_t'(i);
            end
        end
    end

    // release before allocate, a reused slot stays busy
    always_comb begin
        busy_next = busy;
        if (issue_take) begin
            busy_next[pick_slot] = 1'b0;
        end
        if (dispatch_take) begin
            busy_next[alloc_slot] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

    ////////////////////
    // entry payload
    ////////////////////
    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (dispatch_take && alloc_slot == slot_t'(i)) begin
                op_q[i]   <= dispatch.op;
                dest_q[i] <= dispatch.dest;
                // same-cycle bypass from either bus
                src1_q[i] <= snoop(dispatch.src1, cdb, ext_cdb);
                src2_q[i] <= snoop(dispatch.src2, cdb, ext_cdb);
            end else if (busy[i]) begin
                // wakeup of waiting operands
                src1_q[i] <= snoop(src1_q[i], cdb, ext_cdb);
                src2_q[i] <= snoop(src2_q[i], cdb, ext_cdb);
            end
        end
    end

    ////////////////////
    // issue side
    ////////////////////
    // taken entries leave at once, so busy and ready is enough
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            ready_mask[i] = busy[i] && src1_q[i].ready && src2_q[i].ready;
        end
    end

    // operands of the picked slot
    always_comb begin
        issue_word.op   = op_q[pick_slot];
        issue_word.dest = dest_q[pick_slot];
        issue_word.src1 = src1_q[pick_slot].value;
        issue_word.src2 = src2_q[pick_slot].value;
    end

endmodule

/* src.f */
+incdir+design
design/ooo_pkg.sv
design/rs_station.sv
design/issue_select.sv
design/fu_control.sv
design/latency_timer.sv
design/exec_alu.sv
design/ooo_exec_top.sv
bench/ooo_exec_chk.sv
bench/ooo_exec_tb.sv
